//--- build.f
+incdir+source
+incdir+sim
source/cnn_pkg.sv
source/fm_ram.sv
source/window_scanner.sv
source/max_pool_unit.sv
source/conv_mac_unit.sv
source/result_combiner.sv
source/layer_engine_top.sv
sim/tb_layer_engine.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module tb_layer_engine \
	-f build.f -o tb_layer_engine

# A failing run still leaves its log to be searched
./obj_dir/tb_layer_engine > sim.log 2>&1 || true
cat sim.log

if grep -qx "sim passed" sim.log; then
	exit 0
fi
exit 1

//--- sim/tb_ref.svh
`ifndef TB_REF_SVH
`define TB_REF_SVH

// Clamp limits of a 16-bit result
localparam longint REF_MAX = (longint'(1) <<< (`CNN_DATA_W - 1)) - 1;
localparam longint REF_MIN = -(longint'(1) <<< (`CNN_DATA_W - 1));

// Copies of what was loaded into the map RAM and the kernel store
int ref_map [`CNN_FM_SIZE_MAX * `CNN_FM_SIZE_MAX];
int ref_weight [`CNN_KERNEL_MAX * `CNN_KERNEL_MAX];

// Expected outputs of the running layer, by output index
data_t exp_data [1 << `CNN_FM_ADDR_W];
int    exp_count = 0;

// Tallies
int pass_count = 0;
int fail_count = 0;
int err_count = 0;
int err_base = 0;

// Output side per layer type
function automatic int out_side(input layer_cfg_t c);
	if (c.op == OP_POOL) begin
		return int'(c.fm_size) / int'(c.win_size);
	end else begin
		return int'(c.fm_size) - int'(c.win_size) + 1;
	end
endfunction

// Unclamped value of one window
// Conv slides by one, pool steps by its own side
function automatic longint window_raw(input layer_cfg_t c, input int idx);
	int     side;
	int     step;
	int     row0;
	int     col0;
	int     v;
	longint acc;
	side = out_side(c);
	step = (c.op == OP_POOL) ? int'(c.win_size) : 1;
	row0 = (idx / side) * step;
	col0 = (idx % side) * step;
	acc = 0;
	for (int r = 0; r < int'(c.win_size); r++) begin
		for (int k = 0; k < int'(c.win_size); k++) begin
			v = ref_map[(row0 + r) * int'(c.fm_size) + col0 + k];
			if (c.op == OP_POOL) begin
				if ((r == 0 && k == 0) || v > acc) begin
					acc = v;
				end
			end else begin
				acc += longint'(v) * longint'(ref_weight[r * int'(c.win_size) + k]);
			end
		end
	end
	return acc;
endfunction

// Clamp to 16 bits, then ReLU
function automatic data_t expected_value(input layer_cfg_t c, input int idx);
	longint v;
	v = window_raw(c, idx);
	if (v > REF_MAX) begin
		v = REF_MAX;
	end else if (v < REF_MIN) begin
		v = REF_MIN;
	end
	if (c.relu && v < 0) begin
		v = 0;
	end
	return data_t'(v);
endfunction

// Cycles one test may take, layer plus loads plus slack
function automatic int test_budget(input layer_cfg_t c);
	return out_side(c) * out_side(c) * int'(c.win_size) * int'(c.win_size)
		+ int'(c.fm_size) * int'(c.fm_size) + `CNN_KERNEL_MAX * `CNN_KERNEL_MAX + 50;
endfunction

`endif

//--- sim/tb_layer_engine.sv
`timescale 1ns/100ps
`include "cnn_defs.svh"

module tb_layer_engine import cnn_pkg::*; ();

	localparam int CLK_PERIOD = 8;

	// Layer setups used by the tests
	localparam layer_cfg_t CFG_CONV = '{op: OP_CONV, fm_size: 5'd6, win_size: 5'd3, relu: 1'b0};
	localparam layer_cfg_t CFG_POOL = '{op: OP_POOL, fm_size: 5'd6, win_size: 5'd2, relu: 1'b0};
	localparam layer_cfg_t CFG_SAT = '{op: OP_CONV, fm_size: 5'd6, win_size: 5'd3, relu: 1'b0};
	localparam layer_cfg_t CFG_RELU = '{op: OP_CONV, fm_size: 5'd6, win_size: 5'd3, relu: 1'b1};
	localparam layer_cfg_t CFG_IGNORE = '{op: OP_POOL, fm_size: 5'd6, win_size: 5'd3, relu: 1'b0};
	// Sent mid-layer, must never take effect
	localparam layer_cfg_t CFG_STRAY = '{op: OP_CONV, fm_size: 5'd6, win_size: 5'd2, relu: 1'b1};

	logic          clk = 1'b0;
	logic          rst;
	fm_write_t     fm_wr;
	weight_write_t weight_wr;
	logic          start;
	layer_cfg_t    cfg;
	result_t       result;
	logic          layer_done;
	logic          busy;

	// Run state seen by the checks
	string       test_name = "none";
	logic        started = 1'b0;
	int          res_total = 0;
	int          res_base = 0;
	int          done_total = 0;
	int unsigned seed_init;

	`include "tb_ref.svh"

	always #(CLK_PERIOD / 2) clk = ~clk;

	layer_engine_top layer_engine_top_inst (
		.clk          (clk),
		.rst          (rst),
		.fm_wr_i      (fm_wr),
		.weight_wr_i  (weight_wr),
		.start_i      (start),
		.cfg_i        (cfg),
		.result_o     (result),
		.layer_done_o (layer_done),
		.busy_o       (busy)
	);

	// Count results and done pulses
	always @(posedge clk) begin
		if (result.valid) begin
			res_total <= res_total + 1;
		end
		if (layer_done) begin
			done_total <= done_total + 1;
		end
	end

	// Result value against the reference
	data_ok: assert property (@(posedge clk) disable iff (!rst)
		result.valid |-> result.data == exp_data[result.index])
	else begin
		err_count++;
		$display("** Error [%s] data of result %0d: expected %0d, actual %0d", test_name,
			$sampled(result.index), exp_data[$sampled(result.index)], $sampled(result.data));
	end

	// Outputs numbered from zero in row-major order
	index_ok: assert property (@(posedge clk) disable iff (!rst)
		result.valid |-> int'(result.index) == res_total - res_base)
	else begin
		err_count++;
		$display("** Error [%s] result index: expected %0d, actual %0d", test_name,
			$sampled(res_total) - res_base, $sampled(result.index));
	end

	// Done rides on the final result
	done_index_ok: assert property (@(posedge clk) disable iff (!rst)
		layer_done |-> result.valid && int'(result.index) == exp_count - 1)
	else begin
		err_count++;
		$display("** Error [%s] index with layer_done_o: expected %0d, actual %0d", test_name,
			exp_count - 1, $sampled(result.index));
	end

	busy_drop_ok: assert property (@(posedge clk) disable iff (!rst)
		layer_done |=> !busy)
	else begin
		err_count++;
		$display("[%s] busy_o still high the cycle after layer_done_o", test_name);
	end

	busy_fall_ok: assert property (@(posedge clk) disable iff (!rst)
		$fell(busy) |-> $past(layer_done))
	else begin
		err_count++;
		$display("[%s] busy_o fell with no layer_done_o before it", test_name);
	end

	idle_result_ok: assert property (@(posedge clk) disable iff (!rst)
		result.valid |-> busy)
	else begin
		err_count++;
		$display("[%s] result_o.valid while the engine is idle", test_name);
	end

	// Quiet from reset up to the first start
	reset_quiet_ok: assert property (@(posedge clk) disable iff (!rst)
		!started |-> !(result.valid || layer_done || busy))
	else begin
		err_count++;
		$display("[%s] output active before any start", test_name);
	end

	function automatic int rand_range(input int lo, input int hi);
		return lo + int'($urandom % unsigned'(hi - lo + 1));
	endfunction

	// Random map with the right half negated when asked
	task automatic load_map(input int side, input int lo, input int hi, input bit split_sign);
		int v;
		for (int r = 0; r < side; r++) begin
			for (int k = 0; k < side; k++) begin
				v = rand_range(lo, hi);
				if (split_sign && k >= side / 2) begin
					v = -v;
				end
				ref_map[r * side + k] = v;
				@(posedge clk);
				fm_wr <= '{en: 1'b1, addr: 8'(r * side + k), data: data_t'(v)};
			end
		end
		@(posedge clk);
		fm_wr <= '0;
	endtask

	task automatic load_weights(input int lo, input int hi);
		int w;
		for (int i = 0; i < `CNN_KERNEL_MAX * `CNN_KERNEL_MAX; i++) begin
			w = rand_range(lo, hi);
			ref_weight[i] = w;
			@(posedge clk);
			weight_wr <= '{en: 1'b1, index: 4'(i), data: data_t'(w)};
		end
		@(posedge clk);
		weight_wr <= '0;
	endtask

	task automatic report_test(input string name, input int n_results);
		if (err_count == err_base) begin
			pass_count++;
			$display("test %s ok with %0d results", name, n_results);
		end else begin
			fail_count++;
			$display("test %s FAILED with %0d errors", name, err_count - err_base);
		end
	endtask

	// One layer from start to idle with an optional stray start while busy
	task automatic run_layer(input string name, input layer_cfg_t c, input bit stray_start);
		int n_out;
		int limit;
		int cycles;
		int done_start;
		n_out = out_side(c) * out_side(c);
		limit = n_out * int'(c.win_size) * int'(c.win_size) + 20;
		for (int i = 0; i < n_out; i++) begin
			exp_data[i] = expected_value(c, i);
		end
		test_name = name;
		exp_count = n_out;
		err_base = err_count;
		res_base = res_total;
		done_start = done_total;
		@(posedge clk);
		cfg <= c;
		start <= 1'b1;
		started <= 1'b1;
		cycles = 0;
		while (done_total == done_start && cycles < limit) begin
			@(posedge clk);
			cycles++;
			if (stray_start && cycles == 6) begin
				cfg <= CFG_STRAY;
				start <= 1'b1;
			end else begin
				start <= 1'b0;
			end
		end
		if (done_total == done_start) begin
			err_count++;
			$display("[%s] no layer_done_o within %0d cycles of start", name, limit);
		end
		cycles = 0;
		while (busy && cycles < 10) begin
			@(posedge clk);
			cycles++;
		end
		// A wrongly taken start would show up here
		repeat (4) @(posedge clk);
		assert (done_total - done_start == 1) else begin
			err_count++;
			$display("** Error [%s] layer_done_o count: expected 1, actual %0d", name,
				done_total - done_start);
		end
		assert (res_total - res_base == n_out) else begin
			err_count++;
			$display("** Error [%s] result count: expected %0d, actual %0d", name, n_out,
				res_total - res_base);
		end
		assert (!busy) else begin
			err_count++;
			$display("[%s] busy_o still high after the layer", name);
		end
		report_test(name, res_total - res_base);
	endtask

	initial begin
		seed_init = $urandom(69800);
		rst = 1'b0;
		fm_wr = '0;
		weight_wr = '0;
		start = 1'b0;
		cfg = '0;
		repeat (3) @(posedge clk);
		rst <= 1'b1;

		test_name = "reset_idle";
		err_base = err_count;
		repeat (8) @(posedge clk);
		assert (!busy && !layer_done && !result.valid) else begin
			err_count++;
			$display("[reset_idle] outputs active after reset with no start");
		end
		report_test("reset_idle", 0);

		load_map(6, -8, 7, 1'b0);
		load_weights(-8, 7);
		run_layer("conv_3x3", CFG_CONV, 1'b0);

		load_map(6, -2000, 2000, 1'b0);
		run_layer("pool_2x2", CFG_POOL, 1'b0);

		// Large values of one sign per half, so both clamps are hit
		load_map(6, 20000, 32000, 1'b1);
		load_weights(100, 1000);
		run_layer("conv_saturate", CFG_SAT, 1'b0);

		load_map(6, -200, 200, 1'b0);
		load_weights(-50, 50);
		run_layer("conv_relu", CFG_RELU, 1'b0);

		load_map(6, -500, 500, 1'b0);
		run_layer("start_ignored", CFG_IGNORE, 1'b1);

		$display("tests ok: %0d, tests failed: %0d, check errors: %0d", pass_count,
			fail_count, err_count);
		if (fail_count == 0 && err_count == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

	// Watchdog sized from the tests
	initial begin
		int budget;
		budget = 50 + test_budget(CFG_CONV) + test_budget(CFG_POOL) + test_budget(CFG_SAT)
			+ test_budget(CFG_RELU) + test_budget(CFG_IGNORE);
		#(budget * CLK_PERIOD);
		$display("timeout: run still going after %0d clock cycles", budget);
		$display("sim failed");
		$finish;
	end

endmodule

//--- source/layer_engine_top.sv
`timescale 1ns/100ps
`include "cnn_defs.svh"

module layer_engine_top import cnn_pkg::*; (
	input  logic          clk,
	input  logic          rst,
	input  fm_write_t     fm_wr_i,
	input  weight_write_t weight_wr_i,
	input  logic          start_i,
	input  layer_cfg_t    cfg_i,
	output result_t       result_o,
	output logic          layer_done_o,
	output logic          busy_o
);

	// RAM read path
	logic                      rd_en;
	logic [`CNN_FM_ADDR_W-1:0] rd_addr;
	data_t                     rd_data;

	// Shared element stream and layer settings
	win_elem_t elem;
	layer_op_e op;
	logic      relu;

	// Per-unit window results
	win_result_t pool_res;
	win_result_t conv_res;
	logic        layer_done;

	fm_ram fm_ram_inst (
		.clk       (clk),
		.fm_wr_i   (fm_wr_i),
		.rd_en_i   (rd_en),
		.rd_addr_i (rd_addr),
		.rd_data_o (rd_data)
	);

	window_scanner window_scanner_inst (
		.clk          (clk),
		.rst          (rst),
		.start_i      (start_i),
		.cfg_i        (cfg_i),
		.layer_done_i (layer_done),
		.rd_en_o      (rd_en),
		.rd_addr_o    (rd_addr),
		.rd_data_i    (rd_data),
		.elem_o       (elem),
		.op_o         (op),
		.relu_o       (relu),
		.busy_o       (busy_o)
	);

	// Pool and conv work side by side on one stream
	max_pool_unit max_pool_unit_inst (
		.clk      (clk),
		.rst      (rst),
		.elem_i   (elem),
		.result_o (pool_res)
	);

	conv_mac_unit conv_mac_unit_inst (
		.clk         (clk),
		.rst         (rst),
		.weight_wr_i (weight_wr_i),
		.elem_i      (elem),
		.result_o    (conv_res)
	);

	result_combiner result_combiner_inst (
		.clk          (clk),
		.rst          (rst),
		.op_i         (op),
		.relu_i       (relu),
		.pool_i       (pool_res),
		.conv_i       (conv_res),
		.result_o     (result_o),
		.layer_done_o (layer_done)
	);

	assign layer_done_o = layer_done;

endmodule

//--- source/result_combiner.sv
`timescale 1ns/100ps
`include "cnn_defs.svh"

module result_combiner import cnn_pkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  layer_op_e   op_i,
	input  logic        relu_i,
	input  win_result_t pool_i,
	input  win_result_t conv_i,
	output result_t     result_o,
	output logic        layer_done_o
);

	// Clamp limits of the 16-bit output
	localparam data_t DATA_MAX = {1'b0, {(`CNN_DATA_W-1){1'b1}}};
	localparam data_t DATA_MIN = {1'b1, {(`CNN_DATA_W-1){1'b0}}};

	win_result_t               sel;
	acc_t                      sel_val;
	data_t                     sat_val;
	data_t                     out_val;
	logic [`CNN_FM_ADDR_W-1:0] idx_q;
	result_t                   result_q;
	logic                      done_q;

	// Both units see the same stream, keep the one for this layer
	assign sel = (op_i == OP_POOL) ? pool_i : conv_i;
	assign sel_val = sel.value;

	// Saturate to data range, then optional ReLU
	always_comb begin
		if (sel_val > acc_t'(DATA_MAX)) begin
			sat_val = DATA_MAX;
		end else if (sel_val < acc_t'(DATA_MIN)) begin
			sat_val = DATA_MIN;
		end else begin
			sat_val = sel_val[`CNN_DATA_W-1:0];
		end
		// negative results clear to zero
		out_val = (relu_i && sat_val[`CNN_DATA_W-1]) ? '0 : sat_val;
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			result_q <= '0;
			done_q <= 1'b0;
			idx_q <= '0;
		end else begin
			result_q.valid <= sel.valid;
			result_q.index <= idx_q;
			result_q.data <= out_val;
			// Done goes out together with the final result
			done_q <= sel.valid && sel.is_final;
			// Output numbering restarts for the next layer
			if (sel.valid) begin
				idx_q <= sel.is_final ? '0 : idx_q + 1'b1;
			end
		end
	end

	assign result_o = result_q;
	assign layer_done_o = done_q;

endmodule

//--- source/conv_mac_unit.sv
`timescale 1ns/100ps
`include "cnn_defs.svh"

module conv_mac_unit import cnn_pkg::*; (
	input  logic          clk,
	input  logic          rst,
	input  weight_write_t weight_wr_i,
	input  win_elem_t     elem_i,
	output win_result_t   result_o
);

	localparam int N_WEIGHTS = `CNN_KERNEL_MAX * `CNN_KERNEL_MAX;

	// Kernel weights, row-major
	data_t weight_q [N_WEIGHTS];

	data_t                           elem_val;
	data_t                           weight_sel;
	logic signed [2*`CNN_DATA_W-1:0] product;
	acc_t                            acc_q;
	acc_t                            acc_base;
	acc_t                            acc_sum;
	win_result_t                     result_q;

	// Weight load, indices past the kernel store are dropped
	always_ff @(posedge clk) begin
		if (weight_wr_i.en && weight_wr_i.index < N_WEIGHTS) begin
			weight_q[weight_wr_i.index] <= weight_wr_i.data;
		end
	end

	assign elem_val = elem_i.value;
	assign weight_sel = (elem_i.widx < N_WEIGHTS) ? weight_q[elem_i.widx] : '0;
	assign product = elem_val * weight_sel;

	// Sum restarts at each window's first element
	assign acc_base = elem_i.first ? acc_t'(0) : acc_q;
	assign acc_sum = acc_base + acc_t'(product);

	always_ff @(posedge clk) begin
		if (elem_i.valid) begin
			acc_q <= acc_sum;
		end
	end

	// Full-width window sum, saturation happens downstream
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			result_q <= '0;
		end else begin
			result_q.valid <= elem_i.valid && elem_i.last;
			result_q.is_final <= elem_i.valid && elem_i.is_final;
			if (elem_i.valid && elem_i.last) begin
				result_q.value <= acc_sum;
			end
		end
	end

	assign result_o = result_q;

endmodule

//--- source/max_pool_unit.sv
`timescale 1ns/100ps

module max_pool_unit import cnn_pkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  win_elem_t   elem_i,
	output win_result_t result_o
);

	data_t       elem_val;
	data_t       max_q;
	data_t       max_next;
	win_result_t result_q;

	// Signed view of the stream value
	assign elem_val = elem_i.value;

	// New window starts its maximum from the first element
	assign max_next = (elem_i.first || elem_val > max_q) ? elem_val : max_q;

	// Running maximum
	always_ff @(posedge clk) begin
		if (elem_i.valid) begin
			max_q <= max_next;
		end
	end

	// Window result, sign-extended to accumulator width
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			result_q <= '0;
		end else begin
			result_q.valid <= elem_i.valid && elem_i.last;
			result_q.is_final <= elem_i.valid && elem_i.is_final;
			if (elem_i.valid && elem_i.last) begin
				result_q.value <= acc_t'(max_next);
			end
		end
	end

	assign result_o = result_q;

endmodule

//--- source/window_scanner.sv
`timescale 1ns/100ps
`include "cnn_defs.svh"

module window_scanner import cnn_pkg::*; (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      start_i,
	input  layer_cfg_t                cfg_i,
	input  logic                      layer_done_i,
	output logic                      rd_en_o,
	output logic [`CNN_FM_ADDR_W-1:0] rd_addr_o,
	input  data_t                     rd_data_i,
	output win_elem_t                 elem_o,
	output layer_op_e                 op_o,
	output logic                      relu_o,
	output logic                      busy_o
);

	// Room for origin plus step plus window side
	localparam int SUM_W = `CNN_SIZE_W + 2;
	localparam int PROD_W = 2 * `CNN_SIZE_W;

	scan_state_e state_q;
	layer_cfg_t  cfg_q;

	// Window origin and position inside the window
	logic [`CNN_SIZE_W-1:0] org_row_q;
	logic [`CNN_SIZE_W-1:0] org_col_q;
	logic [`CNN_SIZE_W-1:0] win_row_q;
	logic [`CNN_SIZE_W-1:0] win_col_q;
	logic [`CNN_WEIGHT_IDX_W-1:0] widx_q;

	logic [`CNN_SIZE_W-1:0] step;
	logic [`CNN_SIZE_W-1:0] rd_row;
	logic [`CNN_SIZE_W-1:0] rd_col;
	logic [PROD_W-1:0]      rd_addr_full;

	logic win_col_last;
	logic win_row_last;
	logic org_col_last;
	logic org_row_last;
	logic win_first;
	logic win_last;
	logic layer_last;

	// Tags delayed to meet the RAM data
	logic                         tag_valid_q;
	logic                         tag_first_q;
	logic                         tag_last_q;
	logic                         tag_final_q;
	logic [`CNN_WEIGHT_IDX_W-1:0] tag_widx_q;

	// Conv slides by one, pool windows do not overlap
	assign step = (cfg_q.op == OP_POOL) ? cfg_q.win_size : `CNN_SIZE_W'(1);

	// Row-major map address of the current element
	assign rd_row = org_row_q + win_row_q;
	assign rd_col = org_col_q + win_col_q;
	assign rd_addr_full = PROD_W'(rd_row) * PROD_W'(cfg_q.fm_size) + PROD_W'(rd_col);
	assign rd_addr_o = rd_addr_full[`CNN_FM_ADDR_W-1:0];
	assign rd_en_o = (state_q == S_WINDOW);

	assign win_col_last = (win_col_q == cfg_q.win_size - 1'b1);
	assign win_row_last = (win_row_q == cfg_q.win_size - 1'b1);

	// Last origin when one more step would push the window off the map
	// This also fixes the output side for both layer types
	assign org_col_last = (SUM_W'(org_col_q) + SUM_W'(step) + SUM_W'(cfg_q.win_size))
		> SUM_W'(cfg_q.fm_size);
	assign org_row_last = (SUM_W'(org_row_q) + SUM_W'(step) + SUM_W'(cfg_q.win_size))
		> SUM_W'(cfg_q.fm_size);

	assign win_first = (win_row_q == '0) && (win_col_q == '0);
	assign win_last = win_row_last && win_col_last;
	assign layer_last = win_last && org_col_last && org_row_last;

	// Layer control and window walk
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state_q <= S_IDLE;
			cfg_q <= '0;
			org_row_q <= '0;
			org_col_q <= '0;
			win_row_q <= '0;
			win_col_q <= '0;
			widx_q <= '0;
		end else begin
			case (state_q)
				S_IDLE: begin
					if (start_i) begin
						cfg_q <= cfg_i;
						org_row_q <= '0;
						org_col_q <= '0;
						win_row_q <= '0;
						win_col_q <= '0;
						widx_q <= '0;
						state_q <= S_WINDOW;
					end
				end
				S_WINDOW: begin
					if (!win_col_last) begin
						win_col_q <= win_col_q + 1'b1;
						widx_q <= widx_q + 1'b1;
					end else if (!win_row_last) begin
						win_col_q <= '0;
						win_row_q <= win_row_q + 1'b1;
						widx_q <= widx_q + 1'b1;
					end else begin
						// Window done, move origin along the row
						win_col_q <= '0;
						win_row_q <= '0;
						widx_q <= '0;
						if (!org_col_last) begin
							org_col_q <= org_col_q + step;
						end else begin
							org_col_q <= '0;
							if (!org_row_last) begin
								org_row_q <= org_row_q + step;
							end else begin
								// Last address issued, wait for pipeline
								org_row_q <= '0;
								state_q <= S_DRAIN;
							end
						end
					end
				end
				S_DRAIN: begin
					if (layer_done_i) begin
						state_q <= S_IDLE;
					end
				end
				default: begin
					state_q <= S_IDLE;
				end
			endcase
		end
	end

	// One-cycle tag delay, lines up with RAM latency
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			tag_valid_q <= 1'b0;
			tag_first_q <= 1'b0;
			tag_last_q <= 1'b0;
			tag_final_q <= 1'b0;
			tag_widx_q <= '0;
		end else begin
			tag_valid_q <= rd_en_o;
			tag_first_q <= rd_en_o && win_first;
			tag_last_q <= rd_en_o && win_last;
			tag_final_q <= rd_en_o && layer_last;
			tag_widx_q <= widx_q;
		end
	end

	assign elem_o = '{
		valid:    tag_valid_q,
		first:    tag_first_q,
		last:     tag_last_q,
		is_final: tag_final_q,
		widx:     tag_widx_q,
		value:    rd_data_i
	};

	assign op_o = cfg_q.op;
	assign relu_o = cfg_q.relu;
	assign busy_o = (state_q != S_IDLE);

endmodule

//--- source/fm_ram.sv
`timescale 1ns/100ps
`include "cnn_defs.svh"

module fm_ram import cnn_pkg::*; (
	input  logic                      clk,
	input  fm_write_t                 fm_wr_i,
	input  logic                      rd_en_i,
	input  logic [`CNN_FM_ADDR_W-1:0] rd_addr_i,
	output data_t                     rd_data_o
);

	localparam int DEPTH = `CNN_FM_SIZE_MAX * `CNN_FM_SIZE_MAX;

	// Map storage, row-major
	data_t mem [DEPTH];

	// Registered read data
	data_t rd_data_q;

	// Write port
	always_ff @(posedge clk) begin
		if (fm_wr_i.en) begin
			mem[fm_wr_i.addr] <= fm_wr_i.data;
		end
	end

	// Read port, data one cycle after enable
	always_ff @(posedge clk) begin
		if (rd_en_i) begin
			rd_data_q <= mem[rd_addr_i];
		end
	end

	assign rd_data_o = rd_data_q;

endmodule

//--- source/cnn_pkg.sv
`include "cnn_defs.svh"

package cnn_pkg;

	// Signed fixed-point map value
	typedef logic signed [`CNN_DATA_W-1:0] data_t;

	// Signed window accumulator
	typedef logic signed [`CNN_ACC_W-1:0] acc_t;

	// Layer opcodes, numbering follows the layer_type field
	typedef enum logic [3:0] {
		OP_CONV = 4'd1,
		OP_POOL = 4'd2
	} layer_op_e;

	// Window scanner states
	typedef enum logic [1:0] {
		S_IDLE,
		S_WINDOW,
		S_DRAIN
	} scan_state_e;

	// Layer setup, sampled with start
	// win_size is the kernel side for conv and the pool side for pool
	typedef struct packed {
		layer_op_e               op;
		logic [`CNN_SIZE_W-1:0]  fm_size;
		logic [`CNN_SIZE_W-1:0]  win_size;
		logic                    relu;
	} layer_cfg_t;

	// Map RAM write strobe
	typedef struct packed {
		logic                      en;
		logic [`CNN_FM_ADDR_W-1:0] addr;
		data_t                     data;
	} fm_write_t;

	// Kernel weight write strobe
	typedef struct packed {
		logic                         en;
		logic [`CNN_WEIGHT_IDX_W-1:0] index;
		data_t                        data;
	} weight_write_t;

	// One window element on the shared stream
	// is_final marks the last element of the whole layer
	typedef struct packed {
		logic                         valid;
		logic                         first;
		logic                         last;
		logic                         is_final;
		logic [`CNN_WEIGHT_IDX_W-1:0] widx;
		data_t                        value;
	} win_elem_t;

	// Per-window result from a compute unit
	typedef struct packed {
		logic valid;
		logic is_final;
		acc_t value;
	} win_result_t;

	// Engine output word
	typedef struct packed {
		logic                      valid;
		logic [`CNN_FM_ADDR_W-1:0] index;
		data_t                     data;
	} result_t;

endpackage

//--- source/cnn_defs.svh
`ifndef CNN_DEFS_SVH
`define CNN_DEFS_SVH

// Width of one map value or one kernel weight
`define CNN_DATA_W 16

// Accumulator width
// 16x16 product plus headroom for a full kernel sum
`define CNN_ACC_W 36

// Largest feature-map side the RAM can hold
`define CNN_FM_SIZE_MAX 16

// Map RAM address, row-major, CNN_FM_SIZE_MAX squared words
`define CNN_FM_ADDR_W 8

// Size and coordinate fields
`define CNN_SIZE_W 5

// Largest kernel side
`define CNN_KERNEL_MAX 3

// Weight index, row times kernel side plus column
`define CNN_WEIGHT_IDX_W 4

`endif
